/* compile.f */
source/regblk_pkg.sv
source/register_cell.sv
source/avalon_adapter.sv
source/adapter_common.sv
source/regblk_top.sv
tests/regblk_tb.sv

/* tests/regblk_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module regblk_tb
  import regblk_pkg::*;
();

  localparam addr_t BASE        = 8'h40;
  localparam data_t MISS_DATA   = 32'hDEADBEEF;
  localparam int    CYCLE_LIMIT = 2000;       // 6 tests x 40 accesses x 5 cycles, plus margin
  localparam int    RSP_WAIT    = 8;

  logic        clk;
  logic        rst_n;
  avalon_req_t avalon_req;
  avalon_rsp_t avalon_rsp;
  data_t       status_in;
  data_t       irq_set;
  data_t       ctrl;
  logic        irq;

  data_t model_regs [NUM_REGS];               // Entry 2 unused as status reads use status_in
  data_t rng_state;
  int    mismatches;
  int    failures;
  int    cycle_count;
  int    last_latency;                        // Cycles from acceptance to response
  int    last_waits;                          // Cycles stalled by waitrequest

  regblk_top #(
    .BASE_ADDRESS      (BASE),
    .ERROR_STATUS      (1'b1),
    .DEFAULT_READ_DATA (MISS_DATA),
    .INSERT_SLICER     (1'b0)
  ) dut (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_avalon_req (avalon_req),
    .o_avalon_rsp (avalon_rsp),
    .i_status     (status_in),
    .i_irq_set    (irq_set),
    .o_ctrl       (ctrl),
    .o_irq        (irq)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
      $display("Mismatches: %0d, other errors: %0d", mismatches, failures);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic data_t xorshift32(input data_t x);
    data_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic data_t next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic data_t byte_mask(input strb_t be);
    data_t m;
    for (int i = 0; i < STRB_W; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  function automatic data_t model_read(input reg_sel_t idx);
    if (idx == 2'd2) return status_in;
    return model_regs[idx];
  endfunction

  function automatic void model_write(input reg_sel_t idx, input strb_t be, input data_t d);
    data_t m;
    m = byte_mask(be);
    case (idx)
      2'd0, 2'd1: model_regs[idx] = (model_regs[idx] & ~m) | (d & m);
      2'd3:       model_regs[idx] = model_regs[idx] & ~(d & m);  // Write one to clear
      default:    ;
    endcase
  endfunction

  function automatic addr_t reg_addr(input reg_sel_t idx);
    return BASE + addr_t'(idx) * 4;
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      mismatches++;
      $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input rsp_status_e exp, input rsp_status_e act);
    if (exp !== act) begin
      mismatches++;
      $display("MISMATCH %s: expected status %0d, actual status %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      mismatches++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      mismatches++;
      $display("MISMATCH %s: expected %0d cycles, actual %0d cycles", name, exp, act);
    end
  endtask

  task automatic drive_request(input bit is_write, input addr_t addr, input strb_t be,
                               input data_t wdata);
    avalon_req.read       = !is_write;
    avalon_req.write      = is_write;
    avalon_req.address    = addr;
    avalon_req.byteenable = be;
    avalon_req.writedata  = wdata;
  endtask

  task automatic run_access(input string name, input bit is_write, input addr_t addr,
                            input strb_t be, input data_t wdata,
                            output data_t rdata, output rsp_status_e status);
    bit got;
    @(posedge clk);
    #1;
    drive_request(is_write, addr, be, wdata);
    last_waits = 0;
    @(negedge clk);
    while (avalon_rsp.waitrequest && last_waits < RSP_WAIT) begin
      last_waits++;
      @(negedge clk);
    end
    if (avalon_rsp.waitrequest) begin
      failures++;
      $display("%s: waitrequest stayed high for %0d cycles", name, RSP_WAIT);
    end
    @(posedge clk);                           // Accepted on this edge
    #1;
    avalon_req = '0;
    got = 1'b0;
    last_latency = 0;
    rdata = '0;
    status = RSP_OKAY;
    while (!got && last_latency < RSP_WAIT) begin
      @(negedge clk);
      last_latency++;
      got = is_write ? avalon_rsp.writeresponsevalid : avalon_rsp.readdatavalid;
    end
    if (got) begin
      rdata = avalon_rsp.readdata;
      status = avalon_rsp.response;
    end else begin
      failures++;
      $display("%s: no response arrived within %0d cycles of the request", name, RSP_WAIT);
    end
  endtask

  task automatic avalon_write(input string name, input addr_t addr, input strb_t be,
                              input data_t wdata, input rsp_status_e exp_status);
    data_t       rdata;
    rsp_status_e status;
    run_access(name, 1'b1, addr, be, wdata, rdata, status);
    check_status(name, exp_status, status);
  endtask

  task automatic avalon_read(input string name, input addr_t addr, input data_t exp_data,
                             input rsp_status_e exp_status);
    data_t       rdata;
    rsp_status_e status;
    run_access(name, 1'b0, addr, '0, '0, rdata, status);
    check_data(name, exp_data, rdata);
    check_status(name, exp_status, status);
  endtask

  task automatic reset_values();
    for (int i = 0; i < NUM_REGS; i++) begin
      avalon_read("reset_values", reg_addr(reg_sel_t'(i)), '0, RSP_OKAY);
    end
    check_data("reset_values o_ctrl", '0, ctrl);
    check_flag("reset_values o_irq", 1'b0, irq);
  endtask

  task automatic byte_strobes();
    data_t    r;
    data_t    wdata;
    reg_sel_t idx;
    strb_t    be;
    for (int i = 0; i < 20; i++) begin
      r = next_random();
      idx = reg_sel_t'(r[0]);                 // Control or scratch
      be = r[7:4];
      wdata = next_random();
      avalon_write("byte_strobes", reg_addr(idx), be, wdata, RSP_OKAY);
      model_write(idx, be, wdata);
      check_data("byte_strobes o_ctrl", model_regs[0], ctrl);
      avalon_read("byte_strobes", reg_addr(idx), model_read(idx), RSP_OKAY);
      check_count("byte_strobes read latency", 1, last_latency);
      check_count("byte_strobes waitrequest", 0, last_waits);
    end
  endtask

  task automatic read_only_status();
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #1;
      status_in = next_random();
      avalon_read("read_only_status", reg_addr(2'd2), status_in, RSP_OKAY);
      avalon_write("read_only_status", reg_addr(2'd2), 4'hF, next_random(), RSP_OKAY);
      avalon_read("read_only_status", reg_addr(2'd2), status_in, RSP_OKAY);
    end
  endtask

  task automatic interrupt_clear();
    data_t set_bits;
    data_t clear_bits;
    strb_t be;
    for (int i = 0; i < 6; i++) begin
      set_bits = next_random() | 32'h1;
      @(posedge clk);
      #1;
      irq_set = set_bits;
      @(posedge clk);
      #1;
      irq_set = '0;
      model_regs[3] = model_regs[3] | set_bits;
      @(negedge clk);
      check_flag("interrupt_clear o_irq set", 1'b1, irq);
      avalon_read("interrupt_clear", reg_addr(2'd3), model_regs[3], RSP_OKAY);
      clear_bits = next_random();
      be = strb_t'(next_random());
      avalon_write("interrupt_clear", reg_addr(2'd3), be, clear_bits, RSP_OKAY);
      model_write(2'd3, be, clear_bits);
      check_flag("interrupt_clear o_irq", model_regs[3] != '0, irq);
      avalon_read("interrupt_clear", reg_addr(2'd3), model_regs[3], RSP_OKAY);
    end
    avalon_write("interrupt_clear all", reg_addr(2'd3), 4'hF, '1, RSP_OKAY);
    model_write(2'd3, 4'hF, '1);
    check_flag("interrupt_clear o_irq clear", 1'b0, irq);
    avalon_read("interrupt_clear all", reg_addr(2'd3), '0, RSP_OKAY);
  endtask

  task automatic window_errors();
    data_t r;
    addr_t addr;
    for (int i = 0; i < 10; i++) begin
      do begin
        r = next_random();
        addr = r[ADDR_W-1:0];
      end while (addr >= BASE && addr < BASE + 16);
      avalon_write("window_errors", addr, 4'hF, next_random(), RSP_SLVERR);
      avalon_read("window_errors", addr, MISS_DATA, RSP_SLVERR);
    end
    for (int i = 0; i < NUM_REGS; i++) begin
      avalon_read("window_errors readback", reg_addr(reg_sel_t'(i)),
                  model_read(reg_sel_t'(i)), RSP_OKAY);
    end
  endtask

  task automatic back_to_back_traffic();
    bit       op_write [40];
    reg_sel_t op_reg [40];
    strb_t    op_be [40];
    data_t    op_data [40];
    bit       exp_write [$];
    data_t    exp_data [$];
    data_t    r;
    int       issued;
    int       guard;
    bit       exp_w;
    data_t    exp_d;
    for (int i = 0; i < 40; i++) begin
      r = next_random();
      op_write[i] = r[8];
      op_reg[i] = r[1:0];
      op_be[i] = r[7:4];
      op_data[i] = next_random();
    end
    issued = 0;
    guard = 0;
    @(posedge clk);
    #1;
    drive_request(op_write[0], reg_addr(op_reg[0]), op_be[0], op_data[0]);
    while ((issued < 40 || exp_write.size() > 0) && guard < 60) begin
      @(negedge clk);
      guard++;
      if (avalon_rsp.readdatavalid && avalon_rsp.writeresponsevalid) begin
        failures++;
        $display("back_to_back: read and write responses arrived in the same cycle");
      end else if (avalon_rsp.readdatavalid || avalon_rsp.writeresponsevalid) begin
        if (exp_write.size() == 0) begin
          failures++;
          $display("back_to_back: response arrived with no request outstanding");
        end else begin
          exp_w = exp_write.pop_front();
          exp_d = exp_data.pop_front();
          if (exp_w != avalon_rsp.writeresponsevalid) begin
            failures++;
            $display("back_to_back: response of the wrong kind for request order");
          end
          check_status("back_to_back", RSP_OKAY, avalon_rsp.response);
          if (!exp_w) check_data("back_to_back", exp_d, avalon_rsp.readdata);
        end
      end
      if (issued < 40 && !avalon_rsp.waitrequest) begin
        exp_write.push_back(op_write[issued]);
        exp_data.push_back(op_write[issued] ? '0 : model_read(op_reg[issued]));
        if (op_write[issued]) model_write(op_reg[issued], op_be[issued], op_data[issued]);
        issued++;
      end
      @(posedge clk);
      #1;
      if (issued < 40) begin
        drive_request(op_write[issued], reg_addr(op_reg[issued]), op_be[issued],
                      op_data[issued]);
      end else begin
        avalon_req = '0;
      end
    end
    if (issued < 40 || exp_write.size() > 0) begin
      failures++;
      $display("back_to_back: traffic did not complete, %0d responses missing",
               40 - issued + exp_write.size());
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    avalon_req = '0;
    status_in = '0;
    irq_set = '0;
    rng_state = 32'hca057f73;
    mismatches = 0;
    failures = 0;
    cycle_count = 0;
    for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_values();
    byte_strobes();
    read_only_status();
    interrupt_clear();
    window_errors();
    back_to_back_traffic();
    repeat (2) @(posedge clk);
    $display("Mismatches: %0d, other errors: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/regblk_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Register map in offsets from BASE_ADDRESS
//   0x0  control    RW, drives o_ctrl
//   0x4  scratch    RW
//   0x8  status     RO, shows i_status
//   0xC  interrupt  W1C, bits set by i_irq_set
module regblk_top
  import regblk_pkg::*;
#(
  parameter addr_t BASE_ADDRESS      = '0,
  parameter bit    ERROR_STATUS      = 1'b0,
  parameter data_t DEFAULT_READ_DATA = '0,
  parameter bit    INSERT_SLICER     = 1'b0
)(
  input  wire logic        i_clk,
  input  wire logic        i_rst_n,
  input  wire avalon_req_t i_avalon_req,
  output avalon_rsp_t      o_avalon_rsp,
  input  wire data_t       i_status,
  input  wire data_t       i_irq_set,
  output data_t            o_ctrl,
  output logic             o_irq
);

  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  reg_req_t reg_req [NUM_REGS];
  reg_rsp_t reg_rsp [NUM_REGS];
  data_t    irq_value;

  avalon_adapter u_avalon_adapter (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_avalon_req (i_avalon_req),
    .o_avalon_rsp (o_avalon_rsp),
    .o_bus_req    (bus_req),
    .i_bus_rsp    (bus_rsp)
  );

  adapter_common #(
    .BASE_ADDRESS      (BASE_ADDRESS),
    .BYTE_SIZE         (16),               // Four 32-bit words
    .ERROR_STATUS      (ERROR_STATUS),
    .DEFAULT_READ_DATA (DEFAULT_READ_DATA),
    .INSERT_SLICER     (INSERT_SLICER)
  ) u_adapter_common (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_bus_req (bus_req),
    .o_bus_rsp (bus_rsp),
    .o_reg_req (reg_req),
    .i_reg_rsp (reg_rsp)
  );

  register_cell #(.MODE(REG_RW)) u_ctrl (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_reg_req  (reg_req[0]),
    .o_reg_rsp  (reg_rsp[0]),
    .i_hw_value ('0),
    .o_value    (o_ctrl)
  );

  register_cell #(.MODE(REG_RW)) u_scratch (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_reg_req  (reg_req[1]),
    .o_reg_rsp  (reg_rsp[1]),
    .i_hw_value ('0),
    .o_value    ()
  );

  register_cell #(.MODE(REG_RO)) u_status (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_reg_req  (reg_req[2]),
    .o_reg_rsp  (reg_rsp[2]),
    .i_hw_value (i_status),
    .o_value    ()
  );

  register_cell #(.MODE(REG_W1C)) u_irq (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_reg_req  (reg_req[3]),
    .o_reg_rsp  (reg_rsp[3]),
    .i_hw_value (i_irq_set),
    .o_value    (irq_value)
  );

  assign o_irq = |irq_value;              // Any pending interrupt

endmodule

`default_nettype wire

/* source/adapter_common.sv */
`timescale 1ns/1ps
`default_nettype none

module adapter_common
  import regblk_pkg::*;
#(
  parameter addr_t BASE_ADDRESS      = '0,
  parameter int    BYTE_SIZE         = 16,
  parameter bit    ERROR_STATUS      = 1'b0,
  parameter data_t DEFAULT_READ_DATA = '0,
  parameter bit    INSERT_SLICER     = 1'b0
)(
  input  wire logic     i_clk,
  input  wire logic     i_rst_n,
  input  wire bus_req_t i_bus_req,
  output bus_rsp_t      o_bus_rsp,
  output reg_req_t      o_reg_req [NUM_REGS],
  input  wire reg_rsp_t i_reg_rsp [NUM_REGS]
);

  localparam int          WORD_LSB   = $clog2(STRB_W);
  localparam rsp_status_e MISS_STATUS = ERROR_STATUS ? RSP_SLVERR : RSP_OKAY;

  bus_req_t              req;
  logic                  ready;
  addr_t                 offset;
  addr_t                 word_index;
  logic                  in_window;
  logic                  mapped;
  reg_sel_t              sel;
  logic                  done;
  logic [NUM_REGS-1:0]   select_vec;

  generate
    if (INSERT_SLICER) begin : g_slicer
      logic     slice_valid;
      bus_req_t slice_req;

      // Each sliced request completes in the cycle after capture
      always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
          slice_valid <= 1'b0;
        end else begin
          slice_valid <= i_bus_req.valid && !slice_valid;
        end
      end

      always_ff @(posedge i_clk) begin
        if (i_bus_req.valid && !slice_valid) begin
          slice_req <= i_bus_req;
        end
      end

      always_comb begin
        req       = slice_req;
        req.valid = slice_valid;
      end

      assign ready = slice_valid;
    end else begin : g_direct
      assign req   = i_bus_req;
      assign ready = 1'b1;
    end
  endgenerate

  // Window check and register decode
  always_comb begin
    offset     = req.address - BASE_ADDRESS;
    word_index = offset >> WORD_LSB;
    in_window  = (req.address >= BASE_ADDRESS) && (int'(offset) < BYTE_SIZE);
    mapped     = in_window && (int'(word_index) < NUM_REGS);
    sel        = word_index[$bits(reg_sel_t)-1:0];
    done       = req.valid && ready;
  end

  always_comb begin
    for (int i = 0; i < NUM_REGS; i++) begin
      select_vec[i]            = done && mapped && (int'(sel) == i);
      o_reg_req[i].select      = select_vec[i];
      o_reg_req[i].access      = req.access;
      o_reg_req[i].write_data  = req.write_data;
      o_reg_req[i].strobe      = req.strobe;
    end
  end

  always_comb begin
    o_bus_rsp.ready = ready;
    if (mapped) begin
      o_bus_rsp.status    = i_reg_rsp[sel].status;
      o_bus_rsp.read_data = i_reg_rsp[sel].read_data;
    end else begin
      o_bus_rsp.status    = MISS_STATUS;       // Unmapped or outside window
      o_bus_rsp.read_data = DEFAULT_READ_DATA;
    end
  end

  a_one_select: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(select_vec)
  ) else $error("More than one register selected");

endmodule

`default_nettype wire

/* source/avalon_adapter.sv */
`timescale 1ns/1ps
`default_nettype none

module avalon_adapter
  import regblk_pkg::*;
(
  input  wire logic        i_clk,
  input  wire logic        i_rst_n,
  input  wire avalon_req_t i_avalon_req,
  output avalon_rsp_t      o_avalon_rsp,
  output bus_req_t         o_bus_req,
  input  wire bus_rsp_t    i_bus_rsp
);

  bus_req_t    live_req;
  bus_req_t    hold_req;
  logic        pending;                   // Request parked in hold_req
  logic        bus_done;

  logic        rsp_valid;
  bus_access_e rsp_access;
  rsp_status_e rsp_status;
  data_t       rsp_data;

  always_comb begin
    live_req.valid      = i_avalon_req.read || i_avalon_req.write;
    live_req.access     = i_avalon_req.read ? BUS_READ : BUS_WRITE;
    live_req.address    = i_avalon_req.address;
    live_req.write_data = i_avalon_req.writedata;
    live_req.strobe     = i_avalon_req.byteenable;
  end

  assign o_bus_req = pending ? hold_req : live_req;
  assign bus_done  = o_bus_req.valid && i_bus_rsp.ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pending <= 1'b0;
    end else if (bus_done) begin
      pending <= 1'b0;
    end else if (live_req.valid && !pending) begin
      pending <= 1'b1;                    // Not taken in its first cycle
    end
  end

  always_ff @(posedge i_clk) begin
    if (live_req.valid && !pending && !i_bus_rsp.ready) begin
      hold_req <= live_req;
    end
  end

  // Response strobe one cycle after the handshake
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= bus_done;
    end
  end

  always_ff @(posedge i_clk) begin
    if (bus_done) begin
      rsp_access <= o_bus_req.access;
      rsp_status <= i_bus_rsp.status;
      rsp_data   <= i_bus_rsp.read_data;
    end
  end

  always_comb begin
    o_avalon_rsp.waitrequest        = pending;
    o_avalon_rsp.readdatavalid      = rsp_valid && (rsp_access == BUS_READ);
    o_avalon_rsp.writeresponsevalid = rsp_valid && (rsp_access == BUS_WRITE);
    o_avalon_rsp.response           = rsp_status;
    o_avalon_rsp.readdata           = rsp_data;
  end

  a_no_read_and_write: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    !(i_avalon_req.read && i_avalon_req.write)
  ) else $error("Avalon read and write asserted together");

  // Host must hold its request while stalled
  a_stable_while_wait: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (pending && live_req.valid) |=> $stable(i_avalon_req)
  ) else $error("Avalon request changed under waitrequest");

endmodule

`default_nettype wire

/* source/register_cell.sv */
`timescale 1ns/1ps
`default_nettype none

module register_cell
  import regblk_pkg::*;
#(
  parameter reg_mode_e MODE = REG_RW
)(
  input  wire logic     i_clk,
  input  wire logic     i_rst_n,
  input  wire reg_req_t i_reg_req,
  output reg_rsp_t      o_reg_rsp,
  input  wire data_t    i_hw_value,
  output data_t         o_value
);

  data_t bit_mask;
  logic  write_en;

  // Expand byte strobes to a bit mask
  always_comb begin
    for (int i = 0; i < STRB_W; i++) begin
      bit_mask[8*i +: 8] = {8{i_reg_req.strobe[i]}};
    end
  end

  assign write_en = i_reg_req.select && (i_reg_req.access == BUS_WRITE);

  generate
    if (MODE == REG_RO) begin : g_ro
      // Writes are accepted and dropped
      assign o_value = i_hw_value;
    end else if (MODE == REG_W1C) begin : g_w1c
      data_t value;

      always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
          value <= '0;
        end else if (write_en) begin
          value <= (value & ~(i_reg_req.write_data & bit_mask)) | i_hw_value;
        end else begin
          value <= value | i_hw_value;     // Set beats clear
        end
      end

      assign o_value = value;
    end else begin : g_rw
      data_t value;

      always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
          value <= '0;
        end else if (write_en) begin
          value <= (value & ~bit_mask) | (i_reg_req.write_data & bit_mask);
        end
      end

      assign o_value = value;
    end
  endgenerate

  always_comb begin
    o_reg_rsp.read_data = o_value;
    o_reg_rsp.status    = RSP_OKAY;
  end

endmodule

`default_nettype wire

/* source/regblk_pkg.sv */
`default_nettype none

package regblk_pkg;

  localparam int ADDR_W   = 8;
  localparam int DATA_W   = 32;
  localparam int STRB_W   = DATA_W / 8;
  localparam int NUM_REGS = 4;

  typedef logic [ADDR_W-1:0]           addr_t;
  typedef logic [DATA_W-1:0]           data_t;
  typedef logic [STRB_W-1:0]           strb_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_sel_t;

  typedef enum logic {
    BUS_READ,
    BUS_WRITE
  } bus_access_e;

  // Same encoding as the Avalon response field
  typedef enum logic [1:0] {
    RSP_OKAY   = 2'd0,
    RSP_SLVERR = 2'd2,
    RSP_DECERR = 2'd3
  } rsp_status_e;

  typedef enum logic [1:0] {
    REG_RW,
    REG_RO,
    REG_W1C
  } reg_mode_e;

  typedef struct packed {
    logic  read;
    logic  write;
    addr_t address;
    strb_t byteenable;
    data_t writedata;
  } avalon_req_t;

  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    logic        writeresponsevalid;
    rsp_status_e response;
    data_t       readdata;
  } avalon_rsp_t;

  typedef struct packed {
    logic        valid;
    bus_access_e access;
    addr_t       address;
    data_t       write_data;
    strb_t       strobe;
  } bus_req_t;

  typedef struct packed {
    logic        ready;
    rsp_status_e status;
    data_t       read_data;
  } bus_rsp_t;

  typedef struct packed {
    logic        select;
    bus_access_e access;
    data_t       write_data;
    strb_t       strobe;
  } reg_req_t;

  typedef struct packed {
    data_t       read_data;
    rsp_status_e status;
  } reg_rsp_t;

endpackage

`default_nettype wire
